// ==== design/adder_pkg.sv ====
package adder_pkg;

   // Bus widths fixed by the register map
   localparam int data_w = 32;
   localparam int addr_w = 8;

   typedef logic [data_w-1:0]   word_t;
   typedef logic [addr_w-1:0]   addr_t;
   typedef logic [data_w/8-1:0] strb_t;
   typedef logic [1:0]          resp_t;

   localparam resp_t resp_okay   = 2'b00;
   localparam resp_t resp_slverr = 2'b10;

   // Register offsets
   localparam addr_t off_op_a   = 8'h00;
   localparam addr_t off_op_b   = 8'h04;
   localparam addr_t off_sum    = 8'h08;
   localparam addr_t off_status = 8'h0c;

   // Status word bit positions
   localparam int status_bit_carry = 0;
   localparam int status_bit_ready = 1;

   typedef struct packed {
      logic  en;
      addr_t addr;
      word_t data;
      strb_t strb;
   } reg_wr_t;

   typedef struct packed {
      logic  en;
      addr_t addr;
   } reg_rd_req_t;

   typedef struct packed {
      word_t data;
      logic  err;
   } reg_rsp_t;

endpackage

// ==== design/axil_write_slave.sv ====
`timescale 1ns/1ps

module axil_write_slave
(
   input  logic              s1_axi_aclk,
   input  logic              rst_n,
   input  adder_pkg::addr_t  awaddr,
   input  logic              awvalid,
   output logic              awready,
   input  adder_pkg::word_t  wdata,
   input  adder_pkg::strb_t  wstrb,
   input  logic              wvalid,
   output logic              wready,
   output adder_pkg::resp_t  bresp,
   output logic              bvalid,
   input  logic              bready,
   output adder_pkg::reg_wr_t reg_wr,
   input  adder_pkg::reg_rsp_t wr_rsp
);
   import adder_pkg::*;

   typedef enum logic [1:0] {
      wr_idle,
      wr_accept,
      wr_resp
   } wr_state_t;

   wr_state_t state;
   logic      both_valid;

   // Address and data are only taken as a pair
   assign both_valid = awvalid && wvalid;

   always_ff @(posedge s1_axi_aclk)
   begin
      if (!rst_n)
      begin
         state <= wr_idle;
         bresp <= resp_okay;
      end
      else
      begin
         case (state)
            wr_idle:
            begin
               if (both_valid)
               begin
                  state <= wr_accept;
               end
            end
            wr_accept:
            begin
               // Transfer edge where the register write lands
               if (both_valid)
               begin
                  state <= wr_resp;
                  bresp <= wr_rsp.err ? resp_slverr : resp_okay;
               end
               else
               begin
                  state <= wr_idle;
               end
            end
            wr_resp:
            begin
               if (bready)
               begin
                  state <= wr_idle;
               end
            end
            default:
            begin
               state <= wr_idle;
            end
         endcase
      end
   end

   assign awready = (state == wr_accept);
   assign wready  = (state == wr_accept);
   assign bvalid  = (state == wr_resp);

   always_comb
   begin
      reg_wr.en   = (state == wr_accept) && both_valid;
      reg_wr.addr = awaddr;
      reg_wr.data = wdata;
      reg_wr.strb = wstrb;
   end

   bresp_hold_a: assert property (@(posedge s1_axi_aclk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

// ==== design/axil_read_slave.sv ====
`timescale 1ns/1ps

module axil_read_slave
(
   input  logic                    s1_axi_aclk,
   input  logic                    rst_n,
   input  adder_pkg::addr_t        araddr,
   input  logic                    arvalid,
   output logic                    arready,
   output adder_pkg::word_t        rdata,
   output adder_pkg::resp_t        rresp,
   output logic                    rvalid,
   input  logic                    rready,
   output adder_pkg::reg_rd_req_t  reg_rd,
   input  adder_pkg::reg_rsp_t     rd_rsp
);
   import adder_pkg::*;

   typedef enum logic [1:0] {
      rd_idle,
      rd_accept,
      rd_resp
   } rd_state_t;

   rd_state_t state;

   always_ff @(posedge s1_axi_aclk)
   begin
      if (!rst_n)
      begin
         state <= rd_idle;
         rdata <= '0;
         rresp <= resp_okay;
      end
      else
      begin
         case (state)
            rd_idle:
            begin
               if (arvalid)
               begin
                  state <= rd_accept;
               end
            end
            rd_accept:
            begin
               if (arvalid)
               begin
                  state <= rd_resp;
                  rdata <= rd_rsp.data;
                  rresp <= rd_rsp.err ? resp_slverr : resp_okay;
               end
               else
               begin
                  state <= rd_idle;
               end
            end
            rd_resp:
            begin
               // Data bus goes back to zero once taken
               if (rready)
               begin
                  state <= rd_idle;
                  rdata <= '0;
                  rresp <= resp_okay;
               end
            end
            default:
            begin
               state <= rd_idle;
            end
         endcase
      end
   end

   assign arready = (state == rd_accept);
   assign rvalid  = (state == rd_resp);

   always_comb
   begin
      reg_rd.en   = (state == rd_accept) && arvalid;
      reg_rd.addr = araddr;
   end

   r_hold_a: assert property (@(posedge s1_axi_aclk) disable iff (!rst_n)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// ==== design/adder_regs.sv ====
`timescale 1ns/1ps

module adder_regs
(
   input  logic                    s1_axi_aclk,
   input  logic                    rst_n,
   input  adder_pkg::reg_wr_t      reg_wr,
   output adder_pkg::reg_rsp_t     wr_rsp,
   input  adder_pkg::reg_rd_req_t  reg_rd,
   output adder_pkg::reg_rsp_t     rd_rsp
);
   import adder_pkg::*;

   word_t op_a;
   word_t op_b;
   word_t sum;
   logic  carry;
   logic  a_written;
   logic  b_written;
   word_t status;
   logic  wr_a;
   logic  wr_b;
   logic  rd_sum;

   function automatic word_t merge_bytes(input word_t old_val, input word_t new_val,
                                         input strb_t strb);
      word_t result;
      result = old_val;
      for (int i = 0; i < data_w/8; i++)
      begin
         if (strb[i])
         begin
            result[i*8 +: 8] = new_val[i*8 +: 8];
         end
      end
      return result;
   endfunction

   assign wr_a   = reg_wr.en && (reg_wr.addr == off_op_a);
   assign wr_b   = reg_wr.en && (reg_wr.addr == off_op_b);
   assign rd_sum = reg_rd.en && (reg_rd.addr == off_sum);

   // Only the operands are writable
   assign wr_rsp.data = '0;
   assign wr_rsp.err  = (reg_wr.addr != off_op_a) && (reg_wr.addr != off_op_b);

   always_ff @(posedge s1_axi_aclk)
   begin
      if (!rst_n)
      begin
         op_a      <= '0;
         op_b      <= '0;
         sum       <= '0;
         carry     <= 1'b0;
         a_written <= 1'b0;
         b_written <= 1'b0;
      end
      else
      begin
         if (wr_a)
         begin
            op_a <= merge_bytes(op_a, reg_wr.data, reg_wr.strb);
         end
         if (wr_b)
         begin
            op_b <= merge_bytes(op_b, reg_wr.data, reg_wr.strb);
         end
         // One cycle behind the operands
         {carry, sum} <= {1'b0, op_a} + {1'b0, op_b};
         // A write in the same cycle as the sum read wins
         if (wr_a)
         begin
            a_written <= 1'b1;
         end
         else if (rd_sum)
         begin
            a_written <= 1'b0;
         end
         if (wr_b)
         begin
            b_written <= 1'b1;
         end
         else if (rd_sum)
         begin
            b_written <= 1'b0;
         end
      end
   end

   always_comb
   begin
      status = '0;
      status[status_bit_carry] = carry;
      status[status_bit_ready] = a_written && b_written;
   end

   always_comb
   begin
      rd_rsp.data = '0;
      rd_rsp.err  = 1'b0;
      case (reg_rd.addr)
         off_op_a:   rd_rsp.data = op_a;
         off_op_b:   rd_rsp.data = op_b;
         off_sum:    rd_rsp.data = sum;
         off_status: rd_rsp.data = status;
         default:    rd_rsp.err  = 1'b1;
      endcase
   end

   wr_addr_known_a: assert property (@(posedge s1_axi_aclk) disable iff (!rst_n)
      reg_wr.en |-> !$isunknown(reg_wr.addr));

   rd_addr_known_a: assert property (@(posedge s1_axi_aclk) disable iff (!rst_n)
      reg_rd.en |-> !$isunknown(reg_rd.addr));

endmodule

// ==== design/axil_adder_top.sv ====
`timescale 1ns/1ps

module axil_adder_top
(
   input  logic              s1_axi_aclk,
   input  logic              rst_n,
   // Write address
   input  adder_pkg::addr_t  awaddr,
   input  logic              awvalid,
   output logic              awready,
   // Write data
   input  adder_pkg::word_t  wdata,
   input  adder_pkg::strb_t  wstrb,
   input  logic              wvalid,
   output logic              wready,
   // Write response
   output adder_pkg::resp_t  bresp,
   output logic              bvalid,
   input  logic              bready,
   // Read address
   input  adder_pkg::addr_t  araddr,
   input  logic              arvalid,
   output logic              arready,
   // Read data
   output adder_pkg::word_t  rdata,
   output adder_pkg::resp_t  rresp,
   output logic              rvalid,
   input  logic              rready
);
   import adder_pkg::*;

   reg_wr_t     reg_wr;
   reg_rsp_t    wr_rsp;
   reg_rd_req_t reg_rd;
   reg_rsp_t    rd_rsp;

   axil_write_slave u_write (
      .s1_axi_aclk (s1_axi_aclk),
      .rst_n       (rst_n),
      .awaddr      (awaddr),
      .awvalid     (awvalid),
      .awready     (awready),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .wvalid      (wvalid),
      .wready      (wready),
      .bresp       (bresp),
      .bvalid      (bvalid),
      .bready      (bready),
      .reg_wr      (reg_wr),
      .wr_rsp      (wr_rsp)
   );

   axil_read_slave u_read (
      .s1_axi_aclk (s1_axi_aclk),
      .rst_n       (rst_n),
      .araddr      (araddr),
      .arvalid     (arvalid),
      .arready     (arready),
      .rdata       (rdata),
      .rresp       (rresp),
      .rvalid      (rvalid),
      .rready      (rready),
      .reg_rd      (reg_rd),
      .rd_rsp      (rd_rsp)
   );

   adder_regs u_regs (
      .s1_axi_aclk (s1_axi_aclk),
      .rst_n       (rst_n),
      .reg_wr      (reg_wr),
      .wr_rsp      (wr_rsp),
      .reg_rd      (reg_rd),
      .rd_rsp      (rd_rsp)
   );

endmodule

// ==== sim/tb_axil_adder.sv ====
`timescale 1ns/1ps

module tb_axil_adder;
   import adder_pkg::*;

   typedef struct packed {
      logic  is_write;
      addr_t addr;
      word_t data;
      strb_t strb;
      word_t exp_data;
      resp_t exp_resp;
   } stim_t;

   logic        s1_axi_aclk;
   logic        rst_n;
   addr_t       awaddr;
   logic        awvalid;
   logic        awready;
   word_t       wdata;
   strb_t       wstrb;
   logic        wvalid;
   logic        wready;
   resp_t       bresp;
   logic        bvalid;
   logic        bready;
   addr_t       araddr;
   logic        arvalid;
   logic        arready;
   word_t       rdata;
   resp_t       rresp;
   logic        rvalid;
   logic        rready;

   stim_t       stim_q[$];
   logic [31:0] lcg_state;
   word_t       ref_a;
   word_t       ref_b;
   logic        ref_a_wr;
   logic        ref_b_wr;
   int          err_count;
   int          pass_count;
   int          fail_count;
   logic        timed_out;

   axil_adder_top u_dut (
      .s1_axi_aclk (s1_axi_aclk), .rst_n   (rst_n),
      .awaddr      (awaddr),      .awvalid (awvalid), .awready (awready),
      .wdata       (wdata),       .wstrb   (wstrb),   .wvalid  (wvalid),  .wready (wready),
      .bresp       (bresp),       .bvalid  (bvalid),  .bready  (bready),
      .araddr      (araddr),      .arvalid (arvalid), .arready (arready),
      .rdata       (rdata),       .rresp   (rresp),   .rvalid  (rvalid),  .rready (rready)
   );

   initial
   begin
      s1_axi_aclk = 1'b0;
      forever #50 s1_axi_aclk = ~s1_axi_aclk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic word_t apply_strobe(input word_t old_val, input word_t new_val,
                                          input strb_t strb);
      word_t mask;
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      return (old_val & ~mask) | (new_val & mask);
   endfunction

   task automatic note_mismatch(input string name, input word_t exp_val, input word_t got_val);
      $display("mismatch at %0d ns: %s expected 0x%08h, got 0x%08h", $time, name, exp_val,
               got_val);
      err_count++;
   endtask

   // Reference model of the register map
   task automatic push_op(input logic is_write, input addr_t addr, input word_t data,
                          input strb_t strb);
      stim_t       e;
      logic [32:0] full;
      e = '{is_write, addr, data, strb, 32'h0, resp_okay};
      full = {1'b0, ref_a} + {1'b0, ref_b};
      if (is_write)
      begin
         if (addr == off_op_a)
         begin
            ref_a = apply_strobe(ref_a, data, strb);
            ref_a_wr = 1'b1;
         end
         else if (addr == off_op_b)
         begin
            ref_b = apply_strobe(ref_b, data, strb);
            ref_b_wr = 1'b1;
         end
         else
         begin
            e.exp_resp = resp_slverr;
         end
      end
      else
      begin
         case (addr)
            off_op_a: e.exp_data = ref_a;
            off_op_b: e.exp_data = ref_b;
            off_sum:
            begin
               e.exp_data = full[31:0];
               ref_a_wr = 1'b0;
               ref_b_wr = 1'b0;
            end
            off_status:
            begin
               e.exp_data[status_bit_carry] = full[32];
               e.exp_data[status_bit_ready] = ref_a_wr && ref_b_wr;
            end
            default: e.exp_resp = resp_slverr;
         endcase
      end
      stim_q.push_back(e);
   endtask

   task automatic build_table();
      word_t rand_a;
      word_t rand_b;
      // Reset values and all-ones plus one
      push_op(1'b0, off_sum, 32'h0, 4'h0);
      push_op(1'b0, off_status, 32'h0, 4'h0);
      push_op(1'b1, off_op_a, 32'hffff_ffff, 4'hf);
      push_op(1'b0, off_status, 32'h0, 4'h0);
      push_op(1'b1, off_op_b, 32'h0000_0001, 4'hf);
      push_op(1'b0, off_status, 32'h0, 4'h0);
      push_op(1'b0, off_sum, 32'h0, 4'h0);
      push_op(1'b0, off_status, 32'h0, 4'h0);
      push_op(1'b1, off_op_a, 32'h1234_5678, 4'hf);
      push_op(1'b1, off_op_b, 32'h1111_1111, 4'hf);
      push_op(1'b0, off_sum, 32'h0, 4'h0);
      // Partial strobes
      push_op(1'b1, off_op_a, 32'haabb_ccdd, 4'b0101);
      push_op(1'b0, off_op_a, 32'h0, 4'h0);
      push_op(1'b1, off_op_b, 32'hdead_beef, 4'b1000);
      push_op(1'b0, off_op_b, 32'h0, 4'h0);
      push_op(1'b0, off_sum, 32'h0, 4'h0);
      // Read-only and unmapped offsets
      push_op(1'b1, off_sum, 32'h5555_5555, 4'hf);
      push_op(1'b1, off_status, 32'h5555_5555, 4'hf);
      push_op(1'b1, 8'h10, 32'h5555_5555, 4'hf);
      push_op(1'b0, off_op_a, 32'h0, 4'h0);
      push_op(1'b0, off_op_b, 32'h0, 4'h0);
      push_op(1'b0, off_sum, 32'h0, 4'h0);
      push_op(1'b0, 8'h10, 32'h0, 4'h0);
      // Ready flag needs both operands again
      push_op(1'b1, off_op_a, 32'h0000_0100, 4'hf);
      push_op(1'b0, off_status, 32'h0, 4'h0);
      push_op(1'b1, off_op_a, 32'h0000_0200, 4'hf);
      push_op(1'b0, off_status, 32'h0, 4'h0);
      push_op(1'b1, off_op_b, 32'h0000_0300, 4'hf);
      push_op(1'b0, off_status, 32'h0, 4'h0);
      push_op(1'b0, off_sum, 32'h0, 4'h0);
      push_op(1'b0, off_status, 32'h0, 4'h0);
      for (int n = 0; n < 20; n++)
      begin
         rand_a = lcg_next();
         rand_b = lcg_next();
         push_op(1'b1, off_op_a, rand_a, 4'hf);
         push_op(1'b1, off_op_b, rand_b, 4'hf);
         push_op(1'b0, off_sum, 32'h0, 4'h0);
         push_op(1'b0, off_status, 32'h0, 4'h0);
      end
   endtask

   task automatic axil_write(input addr_t addr, input word_t data, input strb_t strb,
                             output resp_t resp);
      int    cnt;
      int    delay;
      resp_t first_resp;
      resp = resp_okay;
      awaddr = addr;
      wdata = data;
      wstrb = strb;
      awvalid = 1'b1;
      wvalid = 1'b1;
      cnt = 0;
      while (!(awready && wready) && cnt < 100)
      begin
         @(posedge s1_axi_aclk);
         #1;
         cnt++;
      end
      if (!(awready && wready))
      begin
         $display("timeout: write to 0x%02h was never accepted", addr);
         timed_out = 1'b1;
         return;
      end
      // Transfer edge
      @(posedge s1_axi_aclk);
      #1;
      awvalid = 1'b0;
      wvalid = 1'b0;
      cnt = 0;
      while (!bvalid && cnt < 100)
      begin
         @(posedge s1_axi_aclk);
         #1;
         cnt++;
      end
      if (!bvalid)
      begin
         $display("timeout: no write response for 0x%02h", addr);
         timed_out = 1'b1;
         return;
      end
      first_resp = bresp;
      delay = lcg_next() % 4;
      for (int i = 0; i < delay; i++)
      begin
         @(posedge s1_axi_aclk);
         #1;
         if (!bvalid)
         begin
            $display("bvalid dropped before bready at %0d ns", $time);
            err_count++;
         end
         if (bresp != first_resp)
            note_mismatch("bresp", 32'(first_resp), 32'(bresp));
      end
      bready = 1'b1;
      @(posedge s1_axi_aclk);
      #1;
      bready = 1'b0;
      if (bvalid)
      begin
         $display("a second write response appeared at %0d ns", $time);
         err_count++;
      end
      resp = first_resp;
   endtask

   task automatic axil_read(input addr_t addr, output word_t data, output resp_t resp);
      int    cnt;
      int    delay;
      word_t first_data;
      resp_t first_resp;
      data = '0;
      resp = resp_okay;
      araddr = addr;
      arvalid = 1'b1;
      cnt = 0;
      while (!arready && cnt < 100)
      begin
         @(posedge s1_axi_aclk);
         #1;
         cnt++;
      end
      if (!arready)
      begin
         $display("timeout: read of 0x%02h was never accepted", addr);
         timed_out = 1'b1;
         return;
      end
      @(posedge s1_axi_aclk);
      #1;
      arvalid = 1'b0;
      cnt = 0;
      while (!rvalid && cnt < 100)
      begin
         @(posedge s1_axi_aclk);
         #1;
         cnt++;
      end
      if (!rvalid)
      begin
         $display("timeout: no read data for 0x%02h", addr);
         timed_out = 1'b1;
         return;
      end
      first_data = rdata;
      first_resp = rresp;
      delay = lcg_next() % 4;
      for (int i = 0; i < delay; i++)
      begin
         @(posedge s1_axi_aclk);
         #1;
         if (!rvalid)
         begin
            $display("rvalid dropped before rready at %0d ns", $time);
            err_count++;
         end
         if (rdata != first_data)
            note_mismatch("rdata", first_data, rdata);
         if (rresp != first_resp)
            note_mismatch("rresp", 32'(first_resp), 32'(rresp));
      end
      rready = 1'b1;
      @(posedge s1_axi_aclk);
      #1;
      rready = 1'b0;
      if (rvalid)
      begin
         $display("a second read response appeared at %0d ns", $time);
         err_count++;
      end
      data = first_data;
      resp = first_resp;
   endtask

   task automatic check_reset_state();
      for (int i = 0; i < 3; i++)
      begin
         @(posedge s1_axi_aclk);
         #1;
         if (awready || wready || bvalid || arready || rvalid)
         begin
            $display("a ready or valid output is high after reset at %0d ns", $time);
            err_count++;
         end
      end
   endtask

   initial
   begin
      stim_t e;
      resp_t resp;
      word_t data;
      int    errs_before;
      rst_n = 1'b0;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      lcg_state = 32'hf291_3a5f;
      ref_a = '0;
      ref_b = '0;
      ref_a_wr = 1'b0;
      ref_b_wr = 1'b0;
      err_count = 0;
      pass_count = 0;
      fail_count = 0;
      timed_out = 1'b0;
      build_table();
      repeat (16) @(posedge s1_axi_aclk);
      #1;
      rst_n = 1'b1;
      check_reset_state();
      if (err_count == 0)
         pass_count++;
      else
         fail_count++;
      $display("reset state: %0d errors", err_count);
      for (int i = 0; i < stim_q.size() && !timed_out; i++)
      begin
         e = stim_q[i];
         errs_before = err_count;
         if (e.is_write)
         begin
            axil_write(e.addr, e.data, e.strb, resp);
            if (!timed_out && resp != e.exp_resp)
               note_mismatch("bresp", 32'(e.exp_resp), 32'(resp));
         end
         else
         begin
            axil_read(e.addr, data, resp);
            if (!timed_out && data != e.exp_data)
               note_mismatch("rdata", e.exp_data, data);
            if (!timed_out && resp != e.exp_resp)
               note_mismatch("rresp", 32'(e.exp_resp), 32'(resp));
         end
         if (err_count == errs_before && !timed_out)
            pass_count++;
         else
            fail_count++;
         $display("entry %0d %s 0x%02h: %0d errors", i, e.is_write ? "write" : "read",
                  e.addr, err_count - errs_before);
      end
      $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
      if (err_count == 0 && fail_count == 0 && !timed_out)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== compile.f ====
design/adder_pkg.sv
design/axil_write_slave.sv
design/axil_read_slave.sv
design/adder_regs.sv
design/axil_adder_top.sv
sim/tb_axil_adder.sv

// ==== Makefile ====
# Verilator build and run for the AXI4-Lite adder
VERILATOR ?= verilator
TOP       ?= tb_axil_adder
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= TEST OK

SRCS    := $(filter %.sv,$(shell cat compile.f))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) compile.f
	$(VERILATOR) $(VFLAGS) -f compile.f --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

check:
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
